// ==== hw/cpuPkg.sv ====
`default_nettype none

package cpuPkg;

    // Machine widths and memory sizes
    localparam int DataWidth    = 32;
    localparam int RegAddrWidth = 5;
    localparam int ImemWords    = 64;
    localparam int DmemWords    = 64;
    localparam int MemAddrWidth = 6;

    typedef logic [DataWidth-1:0]    word_t;
    typedef logic [RegAddrWidth-1:0] regAddr_t;
    typedef logic [MemAddrWidth-1:0] memAddr_t;
    typedef logic [4:0]              shamt_t;

    // Instruction field positions
    localparam int OpcodeLsb = 26;
    localparam int RsLsb     = 21;
    localparam int RtLsb     = 16;
    localparam int RdLsb     = 11;
    localparam int ShamtLsb  = 6;

    localparam logic [5:0] OpRtype = 6'b000000;
    localparam logic [5:0] OpAddi  = 6'b001000;
    localparam logic [5:0] OpLw    = 6'b100011;
    localparam logic [5:0] OpSw    = 6'b101011;
    localparam logic [5:0] OpBeq   = 6'b000100;
    localparam logic [5:0] OpBne   = 6'b000101;

    // R-type function field
    localparam logic [5:0] FnAdd = 6'b100000;
    localparam logic [5:0] FnSub = 6'b100010;
    localparam logic [5:0] FnAnd = 6'b100100;
    localparam logic [5:0] FnOr  = 6'b100101;
    localparam logic [5:0] FnSlt = 6'b101010;
    localparam logic [5:0] FnSll = 6'b000000;

    typedef enum logic [2:0] {AluAdd, AluSub, AluAnd, AluOr, AluSlt, AluSll} aluOp_t;

    // How execute should pick the ALU operation
    typedef enum logic [1:0] {ModeMem, ModeBranch, ModeFunct, ModeAddi} aluMode_t;

    // Host map, byte addresses
    localparam int ApbAddrWidth = 9;
    localparam logic [ApbAddrWidth-1:0] ApbImemBase = 9'h000;
    localparam logic [ApbAddrWidth-1:0] ApbCtrlAddr = 9'h100;
    localparam logic [ApbAddrWidth-1:0] ApbRegBase  = 9'h180;

endpackage

`default_nettype wire

// ==== hw/stageBus.sv ====
`timescale 1ns/100ps
`default_nettype none

// Decode to execute
interface idExBus import cpuPkg::*; ();
    word_t    readData1;
    word_t    readData2;
    word_t    immExt;
    regAddr_t rt;
    regAddr_t rd;
    shamt_t   shamt;
    logic [5:0] funct;
    word_t    pcPlus4;
    aluMode_t aluMode;
    logic     aluSrc;
    logic     regDst;
    logic     branch;
    logic     branchNot;
    logic     memRead;
    logic     memWrite;
    logic     memToReg;
    logic     regWrite;

    modport producer (output readData1, readData2, immExt, rt, rd, shamt, funct, pcPlus4,
        aluMode, aluSrc, regDst, branch, branchNot, memRead, memWrite, memToReg, regWrite);
    modport consumer (input readData1, readData2, immExt, rt, rd, shamt, funct, pcPlus4,
        aluMode, aluSrc, regDst, branch, branchNot, memRead, memWrite, memToReg, regWrite);
endinterface

// Execute to memory
interface exMemBus import cpuPkg::*; ();
    word_t    aluResult;
    logic     zero;
    word_t    branchTarget;
    word_t    storeData;
    regAddr_t destReg;
    logic     branch;
    logic     branchNot;
    logic     memRead;
    logic     memWrite;
    logic     memToReg;
    logic     regWrite;

    modport producer (output aluResult, zero, branchTarget, storeData, destReg,
        branch, branchNot, memRead, memWrite, memToReg, regWrite);
    modport consumer (input aluResult, zero, branchTarget, storeData, destReg,
        branch, branchNot, memRead, memWrite, memToReg, regWrite);
endinterface

`default_nettype wire

// ==== hw/apbHost.sv ====
`timescale 1ns/100ps
`default_nettype none

module apbHost import cpuPkg::*; (
    input  wire logic                    i_clk,
    input  wire logic                    i_rst,
    input  wire logic                    i_psel,
    input  wire logic                    i_penable,
    input  wire logic                    i_pwrite,
    input  wire logic [ApbAddrWidth-1:0] i_paddr,
    input  wire word_t                   i_pwdata,
    input  wire word_t                   i_dbgData,
    output word_t                        o_prdata,
    output logic                         o_pready,
    output logic                         o_pslverr,
    output logic                         o_run,
    output logic                         o_imemWe,
    output memAddr_t                     o_imemAddr,
    output word_t                        o_imemData,
    output regAddr_t                     o_dbgAddr
);

    logic access;
    logic aligned;
    logic imemSel;
    logic ctrlSel;
    logic regSel;
    logic mapped;

    ////////////////////////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////////////////////////
    assign access  = i_psel && i_penable;
    assign aligned = (i_paddr[1:0] == 2'b00);
    // Lower half is program memory
    assign imemSel = aligned && (i_paddr[8] == ApbImemBase[8]);
    assign ctrlSel = (i_paddr == ApbCtrlAddr);
    // Top quarter, one word per register
    assign regSel  = aligned && (i_paddr[8:7] == ApbRegBase[8:7]);
    assign mapped  = imemSel || ctrlSel || regSel;

    // No wait states
    assign o_pready  = access;
    assign o_pslverr = access && (!mapped || (imemSel && !i_pwrite) || (regSel && i_pwrite));

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_run <= 1'b0;
        end else if (access && i_pwrite && ctrlSel) begin
            o_run <= i_pwdata[0];
        end
    end

    assign o_imemWe   = access && i_pwrite && imemSel;
    assign o_imemAddr = i_paddr[MemAddrWidth+1:2];
    assign o_imemData = i_pwdata;
    assign o_dbgAddr  = i_paddr[RegAddrWidth+1:2];

    always_comb begin
        o_prdata = '0;
        if (access && !i_pwrite) begin
            if (ctrlSel) begin
                o_prdata = {{(DataWidth-1){1'b0}}, o_run};
            end else if (regSel) begin
                o_prdata = i_dbgData;
            end
        end
    end

    // Master must keep PSEL for the whole transfer
    penableNeedsPsel: assert property (@(posedge i_clk) disable iff (i_rst)
        i_penable |-> i_psel);

endmodule

`default_nettype wire

// ==== hw/fetchStage.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetchStage import cpuPkg::*; (
    input  wire logic     i_clk,
    input  wire logic     i_rst,
    input  wire logic     i_run,
    input  wire logic     i_imemWe,
    input  wire memAddr_t i_imemAddr,
    input  wire word_t    i_imemData,
    input  wire logic     i_redirect,
    input  wire word_t    i_redirectPc,
    output word_t         o_instr,
    output word_t         o_pcPlus4
);

    word_t imem [ImemWords];
    word_t pc;
    word_t pcPlus4;
    word_t fetched;

    // Program load from the host
    always_ff @(posedge i_clk) begin
        if (i_imemWe) begin
            imem[i_imemAddr] <= i_imemData;
        end
    end

    assign pcPlus4 = pc + 32'd4;
    assign fetched = imem[pc[MemAddrWidth+1:2]];

    // Taken branch from memory stage wins over sequential fetch
    always_ff @(posedge i_clk) begin
        if (i_rst || !i_run) begin
            pc <= '0;
        end else if (i_redirect) begin
            pc <= i_redirectPc;
        end else begin
            pc <= pcPlus4;
        end
    end

    ////////////////////////////////////////////////////////////
    // IF/ID register
    ////////////////////////////////////////////////////////////
    // All zero word is sll $0 and acts as a NOP
    always_ff @(posedge i_clk) begin
        if (i_rst || !i_run) begin
            o_instr <= '0;
        end else begin
            o_instr <= fetched;
        end
    end

    always_ff @(posedge i_clk) begin
        o_pcPlus4 <= pcPlus4;
    end

endmodule

`default_nettype wire

// ==== hw/decodeStage.sv ====
`timescale 1ns/100ps
`default_nettype none

module decodeStage import cpuPkg::*; (
    input  wire logic     i_clk,
    input  wire logic     i_rst,
    input  wire logic     i_run,
    input  wire word_t    i_instr,
    input  wire word_t    i_pcPlus4,
    input  wire logic     i_wbEn,
    input  wire regAddr_t i_wbReg,
    input  wire word_t    i_wbData,
    input  wire regAddr_t i_dbgAddr,
    output word_t         o_dbgData,
    idExBus.producer      idEx
);

    word_t      regFile [2**RegAddrWidth];
    logic [5:0] opcode;
    regAddr_t   rs;
    regAddr_t   rt;
    word_t      rsData;
    word_t      rtData;
    word_t      immExt;
    aluMode_t   aluMode;
    logic       aluSrc;
    logic       regDst;
    logic       branch;
    logic       branchNot;
    logic       memRead;
    logic       memWrite;
    logic       memToReg;
    logic       regWrite;

    // Read with write-through of the writeback result
    function automatic word_t readReg(input regAddr_t addr);
        if (addr == '0) begin
            return '0;
        end
        if (i_wbEn && (i_wbReg == addr)) begin
            return i_wbData;
        end
        return regFile[addr];
    endfunction

    assign opcode = i_instr[OpcodeLsb +: 6];
    assign rs     = i_instr[RsLsb +: RegAddrWidth];
    assign rt     = i_instr[RtLsb +: RegAddrWidth];
    assign immExt = {{16{i_instr[15]}}, i_instr[15:0]};

    ////////////////////////////////////////////////////////////
    // Control decode
    ////////////////////////////////////////////////////////////
    always_comb begin
        aluMode   = ModeFunct;
        aluSrc    = 1'b0;
        regDst    = 1'b0;
        branch    = 1'b0;
        branchNot = 1'b0;
        memRead   = 1'b0;
        memWrite  = 1'b0;
        memToReg  = 1'b0;
        regWrite  = 1'b0;
        case (opcode)
            OpRtype: begin
                regDst   = 1'b1;
                regWrite = 1'b1;
            end
            OpAddi: begin
                aluMode  = ModeAddi;
                aluSrc   = 1'b1;
                regWrite = 1'b1;
            end
            OpLw: begin
                aluMode  = ModeMem;
                aluSrc   = 1'b1;
                memRead  = 1'b1;
                memToReg = 1'b1;
                regWrite = 1'b1;
            end
            OpSw: begin
                aluMode  = ModeMem;
                aluSrc   = 1'b1;
                memWrite = 1'b1;
            end
            OpBeq: begin
                aluMode = ModeBranch;
                branch  = 1'b1;
            end
            OpBne: begin
                aluMode   = ModeBranch;
                branchNot = 1'b1;
            end
            // Unknown opcodes fall through as a bubble
            default: ;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Register file
    ////////////////////////////////////////////////////////////
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 0; i < 2**RegAddrWidth; i++) begin
                regFile[i] <= '0;
            end
        end else if (i_wbEn && (i_wbReg != '0)) begin
            regFile[i_wbReg] <= i_wbData;
        end
    end

    always_comb begin
        rsData    = readReg(rs);
        rtData    = readReg(rt);
        o_dbgData = readReg(i_dbgAddr);
    end

    ////////////////////////////////////////////////////////////
    // ID/EX register
    ////////////////////////////////////////////////////////////
    always_ff @(posedge i_clk) begin
        if (i_rst || !i_run) begin
            idEx.branch    <= 1'b0;
            idEx.branchNot <= 1'b0;
            idEx.memRead   <= 1'b0;
            idEx.memWrite  <= 1'b0;
            idEx.regWrite  <= 1'b0;
        end else begin
            idEx.branch    <= branch;
            idEx.branchNot <= branchNot;
            idEx.memRead   <= memRead;
            idEx.memWrite  <= memWrite;
            idEx.regWrite  <= regWrite;
        end
    end

    always_ff @(posedge i_clk) begin
        idEx.readData1 <= rsData;
        idEx.readData2 <= rtData;
        idEx.immExt    <= immExt;
        idEx.rt        <= rt;
        idEx.rd        <= i_instr[RdLsb +: RegAddrWidth];
        idEx.shamt     <= i_instr[ShamtLsb +: 5];
        idEx.funct     <= i_instr[5:0];
        idEx.pcPlus4   <= i_pcPlus4;
        idEx.aluMode   <= aluMode;
        idEx.aluSrc    <= aluSrc;
        idEx.regDst    <= regDst;
        idEx.memToReg  <= memToReg;
    end

endmodule

`default_nettype wire

// ==== hw/executeStage.sv ====
`timescale 1ns/100ps
`default_nettype none

module executeStage import cpuPkg::*; (
    input wire logic  i_clk,
    input wire logic  i_rst,
    input wire logic  i_run,
    idExBus.consumer  idEx,
    exMemBus.producer exMem
);

    aluOp_t aluOp;
    word_t  operandB;
    word_t  result;

    ////////////////////////////////////////////////////////////
    // ALU control
    ////////////////////////////////////////////////////////////
    always_comb begin
        case (idEx.aluMode)
            ModeMem:    aluOp = AluAdd;
            ModeAddi:   aluOp = AluAdd;
            // Compare by subtraction, zero flag decides
            ModeBranch: aluOp = AluSub;
            default: begin
                case (idEx.funct)
                    FnSub:   aluOp = AluSub;
                    FnAnd:   aluOp = AluAnd;
                    FnOr:    aluOp = AluOr;
                    FnSlt:   aluOp = AluSlt;
                    FnSll:   aluOp = AluSll;
                    default: aluOp = AluAdd;
                endcase
            end
        endcase
    end

    assign operandB = idEx.aluSrc ? idEx.immExt : idEx.readData2;

    always_comb begin
        case (aluOp)
            AluAdd:  result = idEx.readData1 + operandB;
            AluSub:  result = idEx.readData1 - operandB;
            AluAnd:  result = idEx.readData1 & operandB;
            AluOr:   result = idEx.readData1 | operandB;
            AluSlt:  result = {{(DataWidth-1){1'b0}}, $signed(idEx.readData1) < $signed(operandB)};
            // sll shifts rt
            AluSll:  result = operandB << idEx.shamt;
            default: result = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // EX/MEM register
    ////////////////////////////////////////////////////////////
    always_ff @(posedge i_clk) begin
        if (i_rst || !i_run) begin
            exMem.branch    <= 1'b0;
            exMem.branchNot <= 1'b0;
            exMem.memRead   <= 1'b0;
            exMem.memWrite  <= 1'b0;
            exMem.regWrite  <= 1'b0;
        end else begin
            exMem.branch    <= idEx.branch;
            exMem.branchNot <= idEx.branchNot;
            exMem.memRead   <= idEx.memRead;
            exMem.memWrite  <= idEx.memWrite;
            exMem.regWrite  <= idEx.regWrite;
        end
    end

    always_ff @(posedge i_clk) begin
        exMem.aluResult    <= result;
        exMem.zero         <= (result == '0);
        exMem.branchTarget <= idEx.pcPlus4 + {idEx.immExt[DataWidth-3:0], 2'b00};
        exMem.storeData    <= idEx.readData2;
        exMem.destReg      <= idEx.regDst ? idEx.rd : idEx.rt;
        exMem.memToReg     <= idEx.memToReg;
    end

endmodule

`default_nettype wire

// ==== hw/memoryStage.sv ====
`timescale 1ns/100ps
`default_nettype none

module memoryStage import cpuPkg::*; (
    input  wire logic  i_clk,
    input  wire logic  i_rst,
    input  wire logic  i_run,
    exMemBus.consumer  exMem,
    output logic       o_redirect,
    output word_t      o_redirectPc,
    output logic       o_wbEn,
    output regAddr_t   o_wbReg,
    output word_t      o_wbData
);

    word_t    dmem [DmemWords];
    memAddr_t dAddr;
    logic     wbMemToReg;
    word_t    wbAlu;
    word_t    wbLoad;

    // Branch resolves here, delay slots keep running
    assign o_redirect   = (exMem.branch && exMem.zero) || (exMem.branchNot && !exMem.zero);
    assign o_redirectPc = exMem.branchTarget;

    ////////////////////////////////////////////////////////////
    // Data memory, word addressed
    ////////////////////////////////////////////////////////////
    assign dAddr = exMem.aluResult[MemAddrWidth+1:2];

    always_ff @(posedge i_clk) begin
        if (exMem.memWrite) begin
            dmem[dAddr] <= exMem.storeData;
        end
    end

    ////////////////////////////////////////////////////////////
    // MEM/WB register
    ////////////////////////////////////////////////////////////
    always_ff @(posedge i_clk) begin
        if (i_rst || !i_run) begin
            o_wbEn <= 1'b0;
        end else begin
            o_wbEn <= exMem.regWrite;
        end
    end

    always_ff @(posedge i_clk) begin
        o_wbReg    <= exMem.destReg;
        wbAlu      <= exMem.aluResult;
        wbMemToReg <= exMem.memToReg;
        if (exMem.memRead) begin
            wbLoad <= dmem[dAddr];
        end
    end

    assign o_wbData = wbMemToReg ? wbLoad : wbAlu;

    // Decode never makes an instruction both load and store
    noLoadAndStore: assert property (@(posedge i_clk) disable iff (i_rst)
        !(exMem.memRead && exMem.memWrite));

endmodule

`default_nettype wire

// ==== hw/mipsTop.sv ====
`timescale 1ns/100ps
`default_nettype none

module mipsTop import cpuPkg::*; (
    input  wire logic                    i_clk,
    input  wire logic                    i_rst,
    input  wire logic                    i_psel,
    input  wire logic                    i_penable,
    input  wire logic                    i_pwrite,
    input  wire logic [ApbAddrWidth-1:0] i_paddr,
    input  wire word_t                   i_pwdata,
    output word_t                        o_prdata,
    output logic                         o_pready,
    output logic                         o_pslverr
);

    logic     run;
    logic     imemWe;
    memAddr_t imemAddr;
    word_t    imemData;
    regAddr_t dbgAddr;
    word_t    dbgData;
    word_t    instr;
    word_t    pcPlus4;
    logic     redirect;
    word_t    redirectPc;
    logic     wbEn;
    regAddr_t wbReg;
    word_t    wbData;

    idExBus  idEx ();
    exMemBus exMem ();

    ////////////////////////////////////////////////////////////
    // Host port
    ////////////////////////////////////////////////////////////
    apbHost u_apbHost (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_psel     (i_psel),
        .i_penable  (i_penable),
        .i_pwrite   (i_pwrite),
        .i_paddr    (i_paddr),
        .i_pwdata   (i_pwdata),
        .i_dbgData  (dbgData),
        .o_prdata   (o_prdata),
        .o_pready   (o_pready),
        .o_pslverr  (o_pslverr),
        .o_run      (run),
        .o_imemWe   (imemWe),
        .o_imemAddr (imemAddr),
        .o_imemData (imemData),
        .o_dbgAddr  (dbgAddr)
    );

    ////////////////////////////////////////////////////////////
    // Pipeline
    ////////////////////////////////////////////////////////////
    fetchStage u_fetchStage (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_run        (run),
        .i_imemWe     (imemWe),
        .i_imemAddr   (imemAddr),
        .i_imemData   (imemData),
        .i_redirect   (redirect),
        .i_redirectPc (redirectPc),
        .o_instr      (instr),
        .o_pcPlus4    (pcPlus4)
    );

    decodeStage u_decodeStage (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_run     (run),
        .i_instr   (instr),
        .i_pcPlus4 (pcPlus4),
        .i_wbEn    (wbEn),
        .i_wbReg   (wbReg),
        .i_wbData  (wbData),
        .i_dbgAddr (dbgAddr),
        .o_dbgData (dbgData),
        .idEx      (idEx.producer)
    );

    executeStage u_executeStage (
        .i_clk (i_clk),
        .i_rst (i_rst),
        .i_run (run),
        .idEx  (idEx.consumer),
        .exMem (exMem.producer)
    );

    // Closes the loop back to fetch and the register file
    memoryStage u_memoryStage (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_run        (run),
        .exMem        (exMem.consumer),
        .o_redirect   (redirect),
        .o_redirectPc (redirectPc),
        .o_wbEn       (wbEn),
        .o_wbReg      (wbReg),
        .o_wbData     (wbData)
    );

endmodule

`default_nettype wire

// ==== dv/tbClock.sv ====
`timescale 1ns/100ps
`default_nettype none

// Free running testbench clock, 10 ns period
module tbClock (
    output logic o_clk
);

    localparam int HalfPeriod = 5;

    initial begin
        o_clk = 1'b0;
        forever begin
            #(HalfPeriod) o_clk = ~o_clk;
        end
    end

endmodule

`default_nettype wire

// ==== dv/mipsTbPrograms.svh ====
`ifndef MIPS_TB_PROGRAMS_SVH
`define MIPS_TB_PROGRAMS_SVH

localparam int NumCases  = 13;
localparam int ProgWords = 16;
localparam int OperandA  = 100;
localparam int OperandB  = -37;

string caseName [NumCases];
word_t caseProg [NumCases][ProgWords];
int    caseReg  [NumCases];
word_t caseExp  [NumCases];

// Empty program, every word a NOP
task automatic startCase(input int idx, input string name, input int chkReg, input word_t exp);
    caseName[idx] = name;
    caseReg[idx]  = chkReg;
    caseExp[idx]  = exp;
    for (int w = 0; w < ProgWords; w++) begin
        caseProg[idx][w] = '0;
    end
endtask

// Marker into r31, then spin on a branch to itself
task automatic endProgram(input int idx, input int at);
    caseProg[idx][at]     = encI(OpAddi, 0, 31, 1);
    caseProg[idx][at + 1] = encI(OpBeq, 0, 0, -1);
endtask

// r3 = r1 op r2, two NOPs so r2 is visible
task automatic aluCase(input int idx, input string name, input word_t instr, input word_t exp);
    startCase(idx, name, 3, exp);
    caseProg[idx][0] = encI(OpAddi, 0, 1, OperandA);
    caseProg[idx][1] = encI(OpAddi, 0, 2, OperandB);
    caseProg[idx][4] = instr;
    endProgram(idx, 5);
endtask

task automatic addiCase(input int idx, input string name, input int imm1, input int imm2);
    startCase(idx, name, 3, imm1 + imm2);
    caseProg[idx][0] = encI(OpAddi, 0, 1, imm1);
    caseProg[idx][3] = encI(OpAddi, 1, 3, imm2);
    endProgram(idx, 4);
endtask

// Store r1 at 8(r2), load it back into r4
task automatic memCase(input int idx, input int value);
    startCase(idx, "sw lw", 4, value);
    caseProg[idx][0] = encI(OpAddi, 0, 1, value);
    caseProg[idx][1] = encI(OpAddi, 0, 2, 20);
    caseProg[idx][4] = encI(OpSw, 2, 1, 8);
    caseProg[idx][5] = encI(OpLw, 2, 4, 8);
    endProgram(idx, 6);
endtask

// Last delay slot at 7 sets r5 to 1 and word 8 sets 17 only on fall through
task automatic branchCase(input int idx, input string name, input logic [5:0] op,
                          input int rhs, input logic taken);
    startCase(idx, name, 5, taken ? 32'd1 : 32'd17);
    caseProg[idx][0] = encI(OpAddi, 0, 1, 7);
    caseProg[idx][1] = encI(OpAddi, 0, 2, rhs);
    caseProg[idx][4] = encI(op, 1, 2, 4);
    caseProg[idx][7] = encI(OpAddi, 0, 5, 1);
    caseProg[idx][8] = encI(OpAddi, 0, 5, 17);
    endProgram(idx, 9);
endtask

task automatic buildTable();
    word_t a;
    word_t b;
    word_t rnd;
    a = OperandA;
    b = OperandB;
    aluCase(0, "add", encR(1, 2, 3, 0, FnAdd), a + b);
    aluCase(1, "sub", encR(1, 2, 3, 0, FnSub), a - b);
    aluCase(2, "and", encR(1, 2, 3, 0, FnAnd), a & b);
    aluCase(3, "or", encR(1, 2, 3, 0, FnOr), a | b);
    // Smaller operand first
    aluCase(4, "slt", encR(2, 1, 3, 0, FnSlt), ($signed(b) < $signed(a)) ? 32'd1 : 32'd0);
    aluCase(5, "sll", encR(0, 1, 3, 4, FnSll), a << 4);
    // Positive plus negative, then negative plus positive
    for (int k = 0; k < 2; k++) begin
        rnd = nextRandom();
        addiCase(6 + k, $sformatf("addi %0d", k), $signed({k[0], rnd[14:0]}),
                 $signed({~k[0], rnd[30:16]}));
    end
    memCase(8, -1234);
    branchCase(9, "beq taken", OpBeq, 7, 1'b1);
    branchCase(10, "beq not taken", OpBeq, 9, 1'b0);
    branchCase(11, "bne taken", OpBne, 9, 1'b1);
    branchCase(12, "bne not taken", OpBne, 7, 1'b0);
endtask

`endif

// ==== dv/mipsTb.sv ====
`timescale 1ns/100ps
`default_nettype none

module mipsTb import cpuPkg::*; ();

    localparam int ReadyLimit = 8;
    localparam int PollLimit  = 200;

    logic                    clk;
    logic                    rst;
    logic                    psel;
    logic                    penable;
    logic                    pwrite;
    logic [ApbAddrWidth-1:0] paddr;
    word_t                   pwdata;
    word_t                   prdata;
    logic                    pready;
    logic                    pslverr;

    int    errors;
    logic  hung;
    word_t rngState = 32'd93;

    tbClock clockGen (
        .o_clk (clk)
    );

    mipsTop mipsTop_inst (
        .i_clk     (clk),
        .i_rst     (rst),
        .i_psel    (psel),
        .i_penable (penable),
        .i_pwrite  (pwrite),
        .i_paddr   (paddr),
        .i_pwdata  (pwdata),
        .o_prdata  (prdata),
        .o_pready  (pready),
        .o_pslverr (pslverr)
    );

    ////////////////////////////////////////////////////////////
    // Instruction encoding and random numbers
    ////////////////////////////////////////////////////////////
    function automatic word_t encR(input int rs, input int rt, input int rd, input int sh,
                                   input logic [5:0] fn);
        return {OpRtype, rs[4:0], rt[4:0], rd[4:0], sh[4:0], fn};
    endfunction

    function automatic word_t encI(input logic [5:0] op, input int rs, input int rt,
                                   input int imm);
        return {op, rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    // xorshift32
    function automatic word_t nextRandom();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    function automatic logic [ApbAddrWidth-1:0] regAddress(input int r);
        return ApbRegBase + {2'b00, r[4:0], 2'b00};
    endfunction

`include "mipsTbPrograms.svh"

    ////////////////////////////////////////////////////////////
    // APB master
    ////////////////////////////////////////////////////////////
    task automatic apbTransfer(input logic write, input logic [ApbAddrWidth-1:0] addr,
                               input word_t wdata, output word_t rdata, output logic err);
        int waitCycles;
        rdata = '0;
        err   = 1'b0;
        if (hung) begin
            return;
        end
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable    = 1'b1;
        waitCycles = 0;
        @(posedge clk);
        // No wait states allowed in the access cycle
        checkValue("pready in access cycle", 32'd1, {31'd0, pready});
        while (!pready && !hung) begin
            waitCycles++;
            if (waitCycles > ReadyLimit) begin
                $display("No PREADY from address %h within %0d cycles", addr, ReadyLimit);
                errors++;
                hung = 1'b1;
            end else begin
                @(posedge clk);
            end
        end
        rdata = prdata;
        err   = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apbWrite(input logic [ApbAddrWidth-1:0] addr, input word_t data,
                            output logic err);
        word_t unused;
        apbTransfer(1'b1, addr, data, unused, err);
    endtask

    task automatic apbRead(input logic [ApbAddrWidth-1:0] addr, output word_t data,
                           output logic err);
        apbTransfer(1'b0, addr, '0, data, err);
    endtask

    task automatic checkValue(input string name, input word_t expected, input word_t actual);
        assert (actual === expected) else begin
            errors++;
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Test steps
    ////////////////////////////////////////////////////////////
    task automatic checkResetState();
        word_t data;
        logic  err;
        apbRead(ApbCtrlAddr, data, err);
        checkValue("run after reset", 32'd0, data);
        checkValue("ctrl read pslverr", 32'd0, {31'd0, err});
        for (int r = 0; r < 32; r++) begin
            apbRead(regAddress(r), data, err);
            checkValue($sformatf("r%0d after reset", r), 32'd0, data);
        end
    endtask

    task automatic waitForMarker(input string name);
        word_t data;
        logic  err;
        int    polls;
        data  = '0;
        polls = 0;
        while (data !== 32'd1 && !hung) begin
            if (polls == PollLimit) begin
                $display("Case %s did not write its marker to r31 in time", name);
                errors++;
                hung = 1'b1;
            end else begin
                apbRead(regAddress(31), data, err);
                polls++;
            end
        end
    endtask

    task automatic runCase(input int idx);
        word_t data;
        logic  err;
        apbWrite(ApbCtrlAddr, 32'd0, err);
        // Registers only clear on reset, and r31 still holds the last marker
        @(negedge clk);
        rst = 1'b1;
        repeat (2) @(negedge clk);
        rst = 1'b0;
        for (int w = 0; w < ProgWords; w++) begin
            apbWrite(ApbImemBase + {1'b0, w[5:0], 2'b00}, caseProg[idx][w], err);
        end
        apbWrite(ApbCtrlAddr, 32'd1, err);
        waitForMarker(caseName[idx]);
        if (!hung) begin
            apbRead(regAddress(caseReg[idx]), data, err);
            checkValue(caseName[idx], caseExp[idx], data);
        end
    endtask

    // Last program is still spinning, so run stays at 1
    task automatic checkErrorResponses();
        word_t data;
        logic  err;
        apbWrite(ApbCtrlAddr + 9'h004, 32'd0, err);
        checkValue("unmapped write pslverr", 32'd1, {31'd0, err});
        apbRead(ApbCtrlAddr + 9'h004, data, err);
        checkValue("unmapped read pslverr", 32'd1, {31'd0, err});
        apbRead(ApbImemBase + 9'h010, data, err);
        checkValue("imem read pslverr", 32'd1, {31'd0, err});
        apbWrite(regAddress(2), 32'd0, err);
        checkValue("register write pslverr", 32'd1, {31'd0, err});
        apbRead(ApbCtrlAddr, data, err);
        checkValue("run after error responses", 32'd1, data);
    endtask

    initial begin
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        rst     = 1'b1;
        errors  = 0;
        hung    = 1'b0;
        buildTable();
        repeat (2) @(negedge clk);
        rst = 1'b0;

        checkResetState();
        for (int i = 0; i < NumCases && !hung; i++) begin
            runCase(i);
        end
        if (!hung) begin
            checkErrorResponses();
        end

        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+dv
hw/cpuPkg.sv
hw/stageBus.sv
hw/apbHost.sv
hw/fetchStage.sv
hw/decodeStage.sv
hw/executeStage.sv
hw/memoryStage.sv
hw/mipsTop.sv
dv/tbClock.sv
dv/mipsTb.sv
